// ==== source/timekeeper_pkg.sv ====
// Shared bus widths, register map, control bits and response codes; import into each block
package timekeeper_pkg;

  // --------------------------------------------------
  // Bus and time sizes
  // --------------------------------------------------
  localparam int unsigned axil_addr_w = 8;
  localparam int unsigned axil_data_w = 32;
  localparam int unsigned time_w      = 64;
  localparam int unsigned incr_w      = 8;

  // --------------------------------------------------
  // Register offsets (byte addresses)
  // --------------------------------------------------
  // Current time, read only
  localparam logic [axil_addr_w-1:0] reg_time_now_lo      = 8'h00;
  localparam logic [axil_addr_w-1:0] reg_time_now_hi      = 8'h04;
  // Time loaded at the next event
  localparam logic [axil_addr_w-1:0] reg_time_event_lo    = 8'h08;
  localparam logic [axil_addr_w-1:0] reg_time_event_hi    = 8'h0C;
  // Control word
  localparam logic [axil_addr_w-1:0] reg_time_ctrl        = 8'h10;
  // Time captured at the last PPS edge, read only
  localparam logic [axil_addr_w-1:0] reg_time_last_pps_lo = 8'h14;
  localparam logic [axil_addr_w-1:0] reg_time_last_pps_hi = 8'h18;
  // Time-base period in ns, Q32
  localparam logic [axil_addr_w-1:0] reg_period_lo        = 8'h1C;
  localparam logic [axil_addr_w-1:0] reg_period_hi        = 8'h20;

  // --------------------------------------------------
  // Control word bit positions
  // --------------------------------------------------
  localparam int unsigned ctrl_now_bit = 0;
  localparam int unsigned ctrl_pps_bit = 1;

  // --------------------------------------------------
  // AXI response codes
  // --------------------------------------------------
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

endpackage

// ==== source/axil_reg_fsm.sv ====
// AXI4-Lite slave that converts one bus transfer at a time into single-cycle register strobes
`timescale 1ns/1ps

module axil_reg_fsm (
  input  logic                                  tb_clk,
  input  logic                                  tb_rst,
  // Write address and data channels
  input  logic                                  awvalid,
  output logic                                  awready,
  input  logic [timekeeper_pkg::axil_addr_w-1:0] awaddr,
  input  logic                                  wvalid,
  output logic                                  wready,
  input  logic [timekeeper_pkg::axil_data_w-1:0] wdata,
  // Byte strobes ignored, registers are whole words
  input  logic [timekeeper_pkg::axil_data_w/8-1:0] wstrb,
  // Write response channel
  output logic                                  bvalid,
  input  logic                                  bready,
  output logic [1:0]                            bresp,
  // Read channels
  input  logic                                  arvalid,
  output logic                                  arready,
  input  logic [timekeeper_pkg::axil_addr_w-1:0] araddr,
  output logic                                  rvalid,
  input  logic                                  rready,
  output logic [timekeeper_pkg::axil_data_w-1:0] rdata,
  output logic [1:0]                            rresp,
  // Register bank side
  output logic                                  reg_wr,
  output logic                                  reg_rd,
  output logic [timekeeper_pkg::axil_addr_w-1:0] reg_addr,
  output logic [timekeeper_pkg::axil_data_w-1:0] reg_wdata,
  input  logic [timekeeper_pkg::axil_data_w-1:0] reg_rdata,
  input  logic                                  reg_err
);
  import timekeeper_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_accept,
    st_write_resp,
    st_read_resp
  } state_t;

  state_t                 state;
  logic                   is_write;
  logic                   wr_req;
  logic [axil_addr_w-1:0] addr_q;
  logic [axil_data_w-1:0] wdata_q;
  logic [axil_data_w-1:0] rdata_q;
  logic                   err_q;

  // Write needs both address and data present
  assign wr_req = awvalid && wvalid;

  // --------------------------------------------------
  // Transfer sequencing
  // --------------------------------------------------
  always_ff @(posedge tb_clk) begin
    if (tb_rst) begin
      state    <= st_idle;
      is_write <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          // Writes take priority over reads
          if (wr_req) begin
            state    <= st_accept;
            is_write <= 1'b1;
          end else if (arvalid) begin
            state    <= st_accept;
            is_write <= 1'b0;
          end
        end
        st_accept:     state <= is_write ? st_write_resp : st_read_resp;
        st_write_resp: if (bready) state <= st_idle;
        st_read_resp:  if (rready) state <= st_idle;
        default:       state <= st_idle;
      endcase
    end
  end

  // Address and data captured on acceptance, bank answer in the strobe cycle
  always_ff @(posedge tb_clk) begin
    if (state == st_idle) begin
      if (wr_req) begin
        addr_q  <= awaddr;
        wdata_q <= wdata;
      end else if (arvalid) begin
        addr_q  <= araddr;
      end
    end
    if (state == st_accept) begin
      // Error responses carry zero data
      rdata_q <= reg_err ? '0 : reg_rdata;
      err_q   <= reg_err;
    end
  end

  // --------------------------------------------------
  // Handshake outputs
  // --------------------------------------------------
  assign awready   = (state == st_accept) && is_write;
  assign wready    = (state == st_accept) && is_write;
  assign arready   = (state == st_accept) && !is_write;
  assign reg_wr    = (state == st_accept) && is_write;
  assign reg_rd    = (state == st_accept) && !is_write;
  assign reg_addr  = addr_q;
  assign reg_wdata = wdata_q;

  assign bvalid = (state == st_write_resp);
  assign rvalid = (state == st_read_resp);
  assign bresp  = err_q ? resp_slverr : resp_okay;
  assign rresp  = err_q ? resp_slverr : resp_okay;
  assign rdata  = rdata_q;

  // Only one response channel active at a time
  assert property (@(posedge tb_clk) disable iff (tb_rst) !(bvalid && rvalid));

  // Responses hold until taken
  assert property (@(posedge tb_clk) disable iff (tb_rst) bvalid && !bready |=> bvalid);
  assert property (@(posedge tb_clk) disable iff (tb_rst)
    rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

// ==== source/time_regs.sv ====
// Timekeeper register bank: event time, control, period, coherent high words and read decode
`timescale 1ns/1ps

module time_regs (
  input  logic                                  tb_clk,
  input  logic                                  tb_rst,
  // Strobes from the bus FSM
  input  logic                                  reg_wr,
  input  logic                                  reg_rd,
  input  logic [timekeeper_pkg::axil_addr_w-1:0] reg_addr,
  input  logic [timekeeper_pkg::axil_data_w-1:0] reg_wdata,
  output logic [timekeeper_pkg::axil_data_w-1:0] reg_rdata,
  output logic                                  reg_err,
  // Time values from the counter
  input  logic [timekeeper_pkg::time_w-1:0]     timestamp,
  input  logic [timekeeper_pkg::time_w-1:0]     last_pps_time,
  // Controls to the counter
  output logic [timekeeper_pkg::time_w-1:0]     event_time,
  output logic                                  set_now,
  output logic                                  set_pps,
  output logic                                  new_ctrl,
  output logic [timekeeper_pkg::time_w-1:0]     period_ns_q32
);
  import timekeeper_pkg::*;

  // Low word of event time waiting for its high word
  logic [axil_data_w-1:0] event_lo_stage;
  // High words frozen by the low-word read
  logic [axil_data_w-1:0] now_hi_hold;
  logic [axil_data_w-1:0] event_hi_hold;
  logic [axil_data_w-1:0] pps_hi_hold;
  logic                   mapped;
  logic                   read_only;

  // --------------------------------------------------
  // Write side and holding registers
  // --------------------------------------------------
  always_ff @(posedge tb_clk) begin
    if (tb_rst) begin
      event_lo_stage <= '0;
      event_time     <= '0;
      set_now        <= 1'b0;
      set_pps        <= 1'b0;
      new_ctrl       <= 1'b0;
      period_ns_q32  <= '0;
      now_hi_hold    <= '0;
      event_hi_hold  <= '0;
      pps_hi_hold    <= '0;
    end else begin
      new_ctrl <= 1'b0;

      if (reg_wr) begin
        case (reg_addr)
          reg_time_event_lo: event_lo_stage <= reg_wdata;
          // High word commits both halves together
          reg_time_event_hi: event_time <= {reg_wdata, event_lo_stage};
          reg_time_ctrl: begin
            set_now  <= reg_wdata[ctrl_now_bit];
            set_pps  <= reg_wdata[ctrl_pps_bit];
            new_ctrl <= 1'b1;
          end
          reg_period_lo: period_ns_q32[31:0]  <= reg_wdata;
          reg_period_hi: period_ns_q32[63:32] <= reg_wdata;
          // Read-only and unmapped writes change nothing
          default: ;
        endcase
      end

      // Low-word reads snapshot the matching high word
      if (reg_rd) begin
        case (reg_addr)
          reg_time_now_lo:      now_hi_hold   <= timestamp[63:32];
          reg_time_event_lo:    event_hi_hold <= event_time[63:32];
          reg_time_last_pps_lo: pps_hi_hold   <= last_pps_time[63:32];
          default: ;
        endcase
      end
    end
  end

  // --------------------------------------------------
  // Read decode
  // --------------------------------------------------
  always_comb begin
    reg_rdata = '0;
    mapped    = 1'b1;
    read_only = 1'b0;
    case (reg_addr)
      reg_time_now_lo: begin
        reg_rdata = timestamp[31:0];
        read_only = 1'b1;
      end
      reg_time_now_hi: begin
        reg_rdata = now_hi_hold;
        read_only = 1'b1;
      end
      reg_time_event_lo: reg_rdata = event_time[31:0];
      reg_time_event_hi: reg_rdata = event_hi_hold;
      reg_time_ctrl: begin
        reg_rdata[ctrl_now_bit] = set_now;
        reg_rdata[ctrl_pps_bit] = set_pps;
      end
      reg_time_last_pps_lo: begin
        reg_rdata = last_pps_time[31:0];
        read_only = 1'b1;
      end
      reg_time_last_pps_hi: begin
        reg_rdata = pps_hi_hold;
        read_only = 1'b1;
      end
      reg_period_lo: reg_rdata = period_ns_q32[31:0];
      reg_period_hi: reg_rdata = period_ns_q32[63:32];
      default:       mapped = 1'b0;
    endcase
  end

  // Unmapped address, or a write to a status word
  assign reg_err = !mapped || (reg_wr && read_only);

endmodule

// ==== source/time_counter.sv ====
// 64-bit timestamp counter with PPS edge detect, armed time load and last-PPS capture
`timescale 1ns/1ps

module time_counter (
  input  logic                               tb_clk,
  input  logic                               tb_rst,
  input  logic                               sample_stb,
  input  logic                               pps,
  input  logic [timekeeper_pkg::incr_w-1:0]  time_increment,
  // Event setup from the register bank
  input  logic [timekeeper_pkg::time_w-1:0]  event_time,
  input  logic                               set_now,
  input  logic                               set_pps,
  input  logic                               new_ctrl,
  output logic [timekeeper_pkg::time_w-1:0]  timestamp,
  output logic [timekeeper_pkg::time_w-1:0]  last_pps_time
);
  import timekeeper_pkg::*;

  logic              pps_dly;
  logic              pps_edge;
  logic              armed;
  logic              time_event;
  logic [time_w-1:0] incr_ext;
  logic [time_w-1:0] next_count;

  // --------------------------------------------------
  // PPS rising edge, registered
  // --------------------------------------------------
  always_ff @(posedge tb_clk) begin
    if (tb_rst) begin
      pps_dly  <= 1'b0;
      pps_edge <= 1'b0;
    end else begin
      pps_dly  <= pps;
      pps_edge <= pps && !pps_dly;
    end
  end

  assign incr_ext   = {{(time_w - incr_w){1'b0}}, time_increment};
  assign next_count = timestamp + incr_ext;

  // Armed load fires at once or on the next PPS edge
  assign time_event = armed && (set_now || (set_pps && pps_edge));

  // --------------------------------------------------
  // Timestamp and arm flag
  // --------------------------------------------------
  always_ff @(posedge tb_clk) begin
    if (tb_rst) begin
      timestamp <= '0;
      armed     <= 1'b0;
    end else begin
      if (time_event) begin
        timestamp <= event_time;
        armed     <= 1'b0;
      end else if (sample_stb) begin
        timestamp <= next_count;
      end
      // A fresh control write re-arms, even over a firing event
      if (new_ctrl) begin
        armed <= 1'b1;
      end
    end
  end

  // Time seen at the PPS edge, load value takes priority
  always_ff @(posedge tb_clk) begin
    if (tb_rst) begin
      last_pps_time <= '0;
    end else if (pps_edge) begin
      last_pps_time <= time_event ? event_time : next_count;
    end
  end

  // Event disarms unless re-armed in the same cycle
  assert property (@(posedge tb_clk) disable iff (tb_rst)
    time_event && !new_ctrl |=> !armed);

endmodule

// ==== source/timekeeper_top.sv ====
// Timekeeper top level: AXI4-Lite register access to the sample-strobe time base
`timescale 1ns/1ps

module timekeeper_top (
  input  logic                                    tb_clk,
  input  logic                                    tb_rst,
  // AXI4-Lite slave
  input  logic                                    awvalid,
  output logic                                    awready,
  input  logic [timekeeper_pkg::axil_addr_w-1:0]   awaddr,
  input  logic                                    wvalid,
  output logic                                    wready,
  input  logic [timekeeper_pkg::axil_data_w-1:0]   wdata,
  input  logic [timekeeper_pkg::axil_data_w/8-1:0] wstrb,
  output logic                                    bvalid,
  input  logic                                    bready,
  output logic [1:0]                              bresp,
  input  logic                                    arvalid,
  output logic                                    arready,
  input  logic [timekeeper_pkg::axil_addr_w-1:0]   araddr,
  output logic                                    rvalid,
  input  logic                                    rready,
  output logic [timekeeper_pkg::axil_data_w-1:0]   rdata,
  output logic [1:0]                              rresp,
  // Time base
  input  logic                                    sample_stb,
  input  logic                                    pps,
  input  logic [timekeeper_pkg::incr_w-1:0]        time_increment,
  output logic [timekeeper_pkg::time_w-1:0]        timestamp,
  output logic [timekeeper_pkg::time_w-1:0]        last_pps_time,
  output logic [timekeeper_pkg::time_w-1:0]        period_ns_q32
);
  import timekeeper_pkg::*;

  // --------------------------------------------------
  // Register strobe path
  // --------------------------------------------------
  logic                   reg_wr;
  logic                   reg_rd;
  logic [axil_addr_w-1:0] reg_addr;
  logic [axil_data_w-1:0] reg_wdata;
  logic [axil_data_w-1:0] reg_rdata;
  logic                   reg_err;

  // Event setup to the counter
  logic [time_w-1:0]      event_time;
  logic                   set_now;
  logic                   set_pps;
  logic                   new_ctrl;

  axil_reg_fsm u_axil_reg_fsm (
    .tb_clk, .tb_rst,
    .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
    .bvalid, .bready, .bresp,
    .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
    .reg_wr, .reg_rd, .reg_addr, .reg_wdata, .reg_rdata, .reg_err
  );

  time_regs u_time_regs (
    .tb_clk, .tb_rst,
    .reg_wr, .reg_rd, .reg_addr, .reg_wdata, .reg_rdata, .reg_err,
    .timestamp, .last_pps_time,
    .event_time, .set_now, .set_pps, .new_ctrl, .period_ns_q32
  );

  time_counter u_time_counter (
    .tb_clk, .tb_rst,
    .sample_stb, .pps, .time_increment,
    .event_time, .set_now, .set_pps, .new_ctrl,
    .timestamp, .last_pps_time
  );

endmodule

// ==== tb/tb_timekeeper.sv ====
// Self-checking testbench for the timekeeper; replays tb/timekeeper_patterns.txt over AXI4-Lite
`timescale 1ns/1ps

module tb_timekeeper;
  import timekeeper_pkg::*;

  localparam int unsigned timeout_cycles = 200;

  logic                     tb_clk;
  logic                     tb_rst;
  logic                     awvalid;
  logic                     awready;
  logic [axil_addr_w-1:0]   awaddr;
  logic                     wvalid;
  logic                     wready;
  logic [axil_data_w-1:0]   wdata;
  logic [axil_data_w/8-1:0] wstrb;
  logic                     bvalid;
  logic                     bready;
  logic [1:0]               bresp;
  logic                     arvalid;
  logic                     arready;
  logic [axil_addr_w-1:0]   araddr;
  logic                     rvalid;
  logic                     rready;
  logic [axil_data_w-1:0]   rdata;
  logic [1:0]               rresp;
  logic                     sample_stb;
  logic                     pps;
  logic [incr_w-1:0]        time_increment;
  logic [time_w-1:0]        timestamp;
  logic [time_w-1:0]        last_pps_time;
  logic [time_w-1:0]        period_ns_q32;

  integer                   seed;
  integer                   fd;
  integer                   step;
  // Expected period built from accepted period writes
  logic [time_w-1:0]        period_model;

  timekeeper_top u_dut (
    .tb_clk, .tb_rst,
    .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
    .bvalid, .bready, .bresp,
    .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
    .sample_stb, .pps, .time_increment,
    .timestamp, .last_pps_time, .period_ns_q32
  );

  // 8 ns clock
  initial begin
    tb_clk = 1'b0;
    forever begin
      #4 tb_clk = ~tb_clk;
    end
  end

  // --------------------------------------------------
  // Failure reporting and value check
  // --------------------------------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("ERR %s expected 0x%h actual 0x%h", name, expected, actual));
    end
  endtask

  // --------------------------------------------------
  // AXI4-Lite master tasks called on a falling edge
  // --------------------------------------------------
  task automatic axil_write(input logic [axil_addr_w-1:0] addr,
                            input logic [axil_data_w-1:0] data, output logic [1:0] resp);
    int unsigned wait_cnt;
    int unsigned stall;
    awaddr   = addr;
    wdata    = data;
    awvalid  = 1'b1;
    wvalid   = 1'b1;
    wait_cnt = 0;
    // Slave raises both readies together
    while (!(awready && wready)) begin
      @(negedge tb_clk);
      wait_cnt = wait_cnt + 1;
      if (wait_cnt > timeout_cycles) begin
        abort_run("Timeout: awready and wready never rose for a write");
      end
    end
    // Handshake lands on the next rising edge
    @(negedge tb_clk);
    awvalid  = 1'b0;
    wvalid   = 1'b0;
    wait_cnt = 0;
    while (!bvalid) begin
      @(negedge tb_clk);
      wait_cnt = wait_cnt + 1;
      if (wait_cnt > timeout_cycles) begin
        abort_run("Timeout: bvalid never rose after a write");
      end
    end
    // Random back-pressure on bready
    stall = $unsigned($random(seed)) % 4;
    repeat (stall) @(negedge tb_clk);
    resp   = bresp;
    bready = 1'b1;
    @(negedge tb_clk);
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [axil_addr_w-1:0] addr,
                           output logic [axil_data_w-1:0] data, output logic [1:0] resp);
    int unsigned wait_cnt;
    int unsigned stall;
    araddr   = addr;
    arvalid  = 1'b1;
    wait_cnt = 0;
    while (!arready) begin
      @(negedge tb_clk);
      wait_cnt = wait_cnt + 1;
      if (wait_cnt > timeout_cycles) begin
        abort_run("Timeout: arready never rose for a read");
      end
    end
    @(negedge tb_clk);
    arvalid  = 1'b0;
    wait_cnt = 0;
    while (!rvalid) begin
      @(negedge tb_clk);
      wait_cnt = wait_cnt + 1;
      if (wait_cnt > timeout_cycles) begin
        abort_run("Timeout: rvalid never rose after a read");
      end
    end
    // rdata must hold through the stall
    stall = $unsigned($random(seed)) % 4;
    repeat (stall) @(negedge tb_clk);
    data   = rdata;
    resp   = rresp;
    rready = 1'b1;
    @(negedge tb_clk);
    rready = 1'b0;
  endtask

  // --------------------------------------------------
  // One pattern command with its arguments read from the file
  // --------------------------------------------------
  task automatic run_command(input logic [7:0] op);
    integer                 code;
    logic [31:0]            arg0;
    logic [31:0]            arg1;
    logic [31:0]            arg2;
    logic [1:0]             resp;
    logic [axil_data_w-1:0] data;
    logic [8*160-1:0]       rest;
    if (op != "#") begin
      step = step + 1;
    end
    case (op)
      "#": code = $fgets(rest, fd);
      "W": begin
        code = $fscanf(fd, "%h %h %h", arg0, arg1, arg2);
        if (code != 3) begin
          abort_run("Malformed write line in the pattern file");
        end
        axil_write(arg0[axil_addr_w-1:0], arg1, resp);
        check_value($sformatf("step %0d write 0x%02h resp", step, arg0[7:0]),
                    {62'd0, arg2[1:0]}, {62'd0, resp});
        // Only OKAY writes to the period words change it
        if (arg2[1:0] == resp_okay && arg0[7:0] == reg_period_lo) begin
          period_model[31:0] = arg1;
        end else if (arg2[1:0] == resp_okay && arg0[7:0] == reg_period_hi) begin
          period_model[63:32] = arg1;
        end
        check_value($sformatf("step %0d period port", step), period_model, period_ns_q32);
      end
      "R": begin
        code = $fscanf(fd, "%h %h %h", arg0, arg1, arg2);
        if (code != 3) begin
          abort_run("Malformed read line in the pattern file");
        end
        axil_read(arg0[axil_addr_w-1:0], data, resp);
        check_value($sformatf("step %0d read 0x%02h data", step, arg0[7:0]),
                    {32'd0, arg1}, {32'd0, data});
        check_value($sformatf("step %0d read 0x%02h resp", step, arg0[7:0]),
                    {62'd0, arg2[1:0]}, {62'd0, resp});
        // Time ports carry the expected words while the time base is idle
        case (arg0[7:0])
          reg_time_now_lo: begin
            check_value($sformatf("step %0d timestamp port lo", step),
                        {32'd0, arg1}, {32'd0, timestamp[31:0]});
          end
          reg_time_now_hi: begin
            check_value($sformatf("step %0d timestamp port hi", step),
                        {32'd0, arg1}, {32'd0, timestamp[63:32]});
          end
          reg_time_last_pps_lo: begin
            check_value($sformatf("step %0d last pps port lo", step),
                        {32'd0, arg1}, {32'd0, last_pps_time[31:0]});
          end
          reg_time_last_pps_hi: begin
            check_value($sformatf("step %0d last pps port hi", step),
                        {32'd0, arg1}, {32'd0, last_pps_time[63:32]});
          end
          default: ;
        endcase
      end
      "I": begin
        code = $fscanf(fd, "%h", arg0);
        time_increment = arg0[incr_w-1:0];
      end
      "S": begin
        code = $fscanf(fd, "%h", arg0);
        // One strobe per rising edge
        sample_stb = 1'b1;
        repeat (arg0) @(negedge tb_clk);
        sample_stb = 1'b0;
      end
      "P": begin
        pps = 1'b1;
        repeat (3) @(negedge tb_clk);
        pps = 1'b0;
      end
      "N": begin
        code = $fscanf(fd, "%h", arg0);
        repeat (arg0) @(negedge tb_clk);
      end
      default: abort_run($sformatf("Unknown command '%c' in the pattern file", op));
    endcase
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    logic [63:0] token;
    integer      code;
    bit          done;
    tb_rst         = 1'b1;
    awvalid        = 1'b0;
    awaddr         = '0;
    wvalid         = 1'b0;
    wdata          = '0;
    wstrb          = '1;
    bready         = 1'b0;
    arvalid        = 1'b0;
    araddr         = '0;
    rready         = 1'b0;
    sample_stb     = 1'b0;
    pps            = 1'b0;
    time_increment = '0;
    seed           = 32'h2c71_6a08;
    step           = 0;
    period_model   = '0;
    fd = $fopen("tb/timekeeper_patterns.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open the pattern file tb/timekeeper_patterns.txt");
    end
    // Reset for 5 cycles
    repeat (5) @(negedge tb_clk);
    tb_rst = 1'b0;
    @(negedge tb_clk);
    done = 1'b0;
    while (!done) begin
      code = $fscanf(fd, "%s", token);
      if (code != 1) begin
        done = 1'b1;
      end else begin
        run_command(token[7:0]);
      end
    end
    $fclose(fd);
    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== tb/timekeeper_patterns.txt ====
# cmd: W addr data resp | R addr data resp | I incr | S count | P | N cycles
# all fields hex; resp 0 is OKAY and 2 is SLVERR
# reset values
R 10 00000000 0
R 1C 00000000 0
R 20 00000000 0
R 14 00000000 0
R 18 00000000 0
R 00 00000000 0
R 04 00000000 0
# period readback
W 1C 89ABCDEF 0
W 20 00000008 0
R 1C 89ABCDEF 0
R 20 00000008 0
# immediate load with no strobes
W 08 DEADBEEF 0
W 0C 12345678 0
W 10 00000001 0
N 3
R 00 DEADBEEF 0
R 04 12345678 0
R 08 DEADBEEF 0
R 0C 12345678 0
# count across the word boundary
W 08 FFFFFFF0 0
W 0C 00000001 0
W 10 00000001 0
N 3
I 04
S 8
R 00 00000010 0
R 04 00000002 0
# load on the next PPS edge
W 08 00000100 0
W 0C 00000005 0
W 10 00000002 0
N 3
R 00 00000010 0
R 04 00000002 0
P
N 4
R 00 00000100 0
R 04 00000005 0
R 14 00000100 0
R 18 00000005 0
# second PPS without a new arm
P
N 4
R 14 00000104 0
R 18 00000005 0
# error responses leave registers alone
W 00 11111111 2
W 40 22222222 2
R 40 00000000 2
R 1C 89ABCDEF 0
R 08 00000100 0
R 00 00000100 0
R 04 00000005 0

// ==== src.f ====
source/timekeeper_pkg.sv
source/axil_reg_fsm.sv
source/time_regs.sv
source/time_counter.sv
source/timekeeper_top.sv
tb/tb_timekeeper.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and succeed only when the pass line appears in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module tb_timekeeper \
  -o tb_timekeeper || { echo "Build failed"; exit 1; }
out=$(./obj_dir/tb_timekeeper 2>&1)
echo "$out"
echo "$out" | grep -q "Finished with no errors" && echo "PASS" || { echo "FAIL"; exit 1; }
